/* verilog/tlb_pkg.sv */
package tlb_pkg;

    ////////////////////
    // page numbers
    ////////////////////

    localparam int unsigned VPN_W  = 27;    // sv39 virtual page number
    localparam int unsigned PPN_W  = 20;
    localparam int unsigned ASID_W = 4;

    ////////////////////
    // organisation
    ////////////////////

    localparam int unsigned TLB_SETS = 16;
    localparam int unsigned SET_W    = $clog2(TLB_SETS);  // low vpn bits pick the set

    // set bits are implied by the index, only the rest is stored
    localparam int unsigned TAG_W = VPN_W - SET_W;

    localparam int unsigned TLB_WAYS = 2;
    localparam int unsigned LFSR_W   = 8;   // random victim source

    ////////////////////
    // lookup source
    ////////////////////

    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_ITLB = 2'd1,
        SRC_DTLB = 2'd2
    } req_src_e;

endpackage

/* verilog/tlb_miss_arbiter.sv */
module tlb_miss_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       enable_translation_i,
    input  logic                       en_ld_st_translation_i,
    input  logic                       itlb_access_i,
    input  logic                       itlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  itlb_vpn_i,
    input  logic                       dtlb_access_i,
    input  logic                       dtlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  dtlb_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0] asid_i,
    output logic                       itlb_miss_o,
    output logic                       dtlb_miss_o,
    output logic [tlb_pkg::SET_W-1:0]  lookup_set_o,
    output tlb_pkg::req_src_e          lookup_src_o,
    output logic [tlb_pkg::VPN_W-1:0]  lookup_vpn_o,
    output logic [tlb_pkg::ASID_W-1:0] lookup_asid_o
);
    import tlb_pkg::*;

    logic             serve_i;
    logic             serve_d;
    logic [VPN_W-1:0] sel_vpn;
    req_src_e         src_q;
    logic [VPN_W-1:0] vpn_q;
    logic [ASID_W-1:0] asid_q;

    // data side wins, fetch only goes when the dtlb is idle
    assign serve_d = !flush_i && en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;
    assign serve_i = !flush_i && enable_translation_i && itlb_access_i && !itlb_hit_i
                     && !dtlb_access_i;

    assign itlb_miss_o = serve_i;
    assign dtlb_miss_o = serve_d;

    assign sel_vpn      = serve_d ? dtlb_vpn_i : itlb_vpn_i;
    assign lookup_set_o = sel_vpn[SET_W-1:0];   // way stores read this cycle

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            src_q <= SRC_NONE;
        end else begin
            src_q <= serve_d ? SRC_DTLB : (serve_i ? SRC_ITLB : SRC_NONE);
        end
    end

    // compare operands, only meaningful while src_q is set
    always_ff @(posedge clk_i) begin
        if (serve_d || serve_i) begin
            vpn_q  <= sel_vpn;
            asid_q <= asid_i;
        end
    end

    assign lookup_src_o  = src_q;
    assign lookup_vpn_o  = vpn_q;
    assign lookup_asid_o = asid_q;

    miss_exclusive_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_miss_o && dtlb_miss_o))
        else $error("itlb and dtlb miss served together");

endmodule

/* verilog/tlb_way_store.sv */
module tlb_way_store (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic [tlb_pkg::SET_W-1:0]    rd_set_i,
    input  logic                         wr_en_i,
    input  logic [tlb_pkg::VPN_W-1:0]    wr_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0]   wr_asid_i,
    input  logic [tlb_pkg::PPN_W-1:0]    wr_ppn_i,
    input  logic                         wr_global_i,
    input  logic                         flush_i,
    input  logic [tlb_pkg::VPN_W-1:0]    flush_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0]   flush_asid_i,
    output logic [tlb_pkg::TLB_SETS-1:0] valid_vec_o,
    output logic                         rd_valid_o,
    output logic [tlb_pkg::TAG_W-1:0]    rd_tag_o,
    output logic [tlb_pkg::ASID_W-1:0]   rd_asid_o,
    output logic [tlb_pkg::PPN_W-1:0]    rd_ppn_o,
    output logic                         rd_global_o
);
    import tlb_pkg::*;

    logic [TLB_SETS-1:0] valid_q;
    logic [TAG_W-1:0]    tag_q    [TLB_SETS];
    logic [ASID_W-1:0]   asid_q   [TLB_SETS];
    logic [PPN_W-1:0]    ppn_q    [TLB_SETS];
    logic                global_q [TLB_SETS];

    logic [SET_W-1:0]    wr_set;
    logic [SET_W-1:0]    flush_set;
    logic [TAG_W-1:0]    flush_tag;
    logic                flush_vpn_zero;
    logic                flush_asid_zero;
    logic [TLB_SETS-1:0] flush_hit;

    assign wr_set          = wr_vpn_i[SET_W-1:0];
    assign flush_set       = flush_vpn_i[SET_W-1:0];
    assign flush_tag       = flush_vpn_i[VPN_W-1:SET_W];
    assign flush_vpn_zero  = ~(|flush_vpn_i);
    assign flush_asid_zero = ~(|flush_asid_i);

    ////////////////////
    // sfence decode
    ////////////////////

    always_comb begin : flush_match
        for (int s = 0; s < TLB_SETS; s++) begin
            if (flush_vpn_zero && flush_asid_zero) begin
                flush_hit[s] = 1'b1;                                // sfence x0, x0
            end else if (flush_asid_zero) begin
                flush_hit[s] = (SET_W'(s) == flush_set) && (tag_q[s] == flush_tag);
            end else if (!flush_vpn_zero) begin
                // addressed entry in one address space
                flush_hit[s] = (SET_W'(s) == flush_set) && (tag_q[s] == flush_tag)
                               && (asid_q[s] == flush_asid_i) && !global_q[s];
            end else begin
                flush_hit[s] = (asid_q[s] == flush_asid_i) && !global_q[s]; // globals survive
            end
        end
    end

    ////////////////////
    // entry arrays
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= valid_q & ~flush_hit;
            end
            if (wr_en_i) begin
                valid_q[wr_set] <= 1'b1;   // never together with a flush
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[wr_set]    <= wr_vpn_i[VPN_W-1:SET_W];
            asid_q[wr_set]   <= wr_asid_i;
            ppn_q[wr_set]    <= wr_ppn_i;
            global_q[wr_set] <= wr_global_i;
        end
    end

    // registered read port, data valid one cycle after rd_set_i
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= valid_q[rd_set_i];
        end
    end

    always_ff @(posedge clk_i) begin
        rd_tag_o    <= tag_q[rd_set_i];
        rd_asid_o   <= asid_q[rd_set_i];
        rd_ppn_o    <= ppn_q[rd_set_i];
        rd_global_o <= global_q[rd_set_i];
    end

    assign valid_vec_o = valid_q;

endmodule

/* verilog/tlb_replacement.sv */
module tlb_replacement (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         upd_valid_i,
    input  logic [tlb_pkg::SET_W-1:0]    upd_set_i,
    input  logic [tlb_pkg::TLB_SETS-1:0] way0_valid_i,
    input  logic [tlb_pkg::TLB_SETS-1:0] way1_valid_i,
    output logic [tlb_pkg::TLB_WAYS-1:0] wr_way_o
);
    import tlb_pkg::*;

    logic [TLB_WAYS-1:0] set_valid;
    logic                set_full;
    logic [LFSR_W-1:0]   lfsr_q;

    assign set_valid = {way1_valid_i[upd_set_i], way0_valid_i[upd_set_i]};
    assign set_full  = &set_valid;

    always_comb begin : pick_way
        wr_way_o = '0;
        if (upd_valid_i) begin
            if (!set_valid[0]) begin
                wr_way_o[0] = 1'b1;             // lowest free way first
            end else if (!set_valid[1]) begin
                wr_way_o[1] = 1'b1;
            end else begin
                wr_way_o[lfsr_q[0]] = 1'b1;     // set full, random victim
            end
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= 8'hA5;
        end else if (upd_valid_i && set_full) begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    way_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        upd_valid_i |-> $onehot(wr_way_o))
        else $error("replacement way is not one-hot on update");

endmodule

/* verilog/tlb_hit_select.sv */
module tlb_hit_select (
    input  tlb_pkg::req_src_e                                  lookup_src_i,
    input  logic [tlb_pkg::VPN_W-1:0]                          lookup_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0]                         lookup_asid_i,
    input  logic [tlb_pkg::TLB_WAYS-1:0]                       way_valid_i,
    input  logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::TAG_W-1:0]   way_tag_i,
    input  logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::ASID_W-1:0]  way_asid_i,
    input  logic [tlb_pkg::TLB_WAYS-1:0][tlb_pkg::PPN_W-1:0]   way_ppn_i,
    input  logic [tlb_pkg::TLB_WAYS-1:0]                       way_global_i,
    output logic                                               shared_hit_o,
    output logic                                               itlb_refill_valid_o,
    output logic                                               dtlb_refill_valid_o,
    output logic [tlb_pkg::VPN_W-1:0]                          refill_vpn_o,
    output logic [tlb_pkg::ASID_W-1:0]                         refill_asid_o,
    output logic [tlb_pkg::PPN_W-1:0]                          refill_ppn_o,
    output logic                                               refill_global_o
);
    import tlb_pkg::*;

    logic [TAG_W-1:0]    lookup_tag;
    logic [TLB_WAYS-1:0] way_hit;
    logic                any_hit;

    assign lookup_tag = lookup_vpn_i[VPN_W-1:SET_W];

    always_comb begin : tag_compare
        for (int w = 0; w < TLB_WAYS; w++) begin
            way_hit[w] = way_valid_i[w] && (way_tag_i[w] == lookup_tag)
                         && ((way_asid_i[w] == lookup_asid_i) || way_global_i[w]);
        end
    end

    assign any_hit = (|way_hit) && (lookup_src_i != SRC_NONE);

    // mux out the hitting way
    always_comb begin : refill_mux
        refill_ppn_o    = '0;
        refill_global_o = 1'b0;
        for (int w = 0; w < TLB_WAYS; w++) begin
            if (way_hit[w]) begin
                refill_ppn_o    = way_ppn_i[w];
                refill_global_o = way_global_i[w];
            end
        end
    end

    assign shared_hit_o        = any_hit;
    assign itlb_refill_valid_o = any_hit && (lookup_src_i == SRC_ITLB);
    assign dtlb_refill_valid_o = any_hit && (lookup_src_i == SRC_DTLB);
    assign refill_vpn_o        = lookup_vpn_i;
    assign refill_asid_o       = lookup_asid_i;

    // a page lives in one way only since the walker refills on misses
    multi_hit_a: assert final ($onehot0(way_hit) || (lookup_src_i == SRC_NONE))
        else $error("both ways hit the same lookup");

endmodule

/* verilog/shared_tlb.sv */
module shared_tlb (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // csr
    input  logic                       enable_translation_i,
    input  logic                       en_ld_st_translation_i,
    input  logic [tlb_pkg::ASID_W-1:0] asid_i,
    // l1 tlb misses
    input  logic                       itlb_access_i,
    input  logic                       itlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  itlb_vpn_i,
    input  logic                       dtlb_access_i,
    input  logic                       dtlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  dtlb_vpn_i,
    // walker update
    input  logic                       upd_valid_i,
    input  logic [tlb_pkg::VPN_W-1:0]  upd_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0] upd_asid_i,
    input  logic [tlb_pkg::PPN_W-1:0]  upd_ppn_i,
    input  logic                       upd_global_i,
    // sfence.vma
    input  logic                       flush_i,
    input  logic [tlb_pkg::ASID_W-1:0] flush_asid_i,
    input  logic [tlb_pkg::VPN_W-1:0]  flush_vpn_i,
    // misses and refill
    output logic                       itlb_miss_o,
    output logic                       dtlb_miss_o,
    output logic                       itlb_refill_valid_o,
    output logic                       dtlb_refill_valid_o,
    output logic [tlb_pkg::VPN_W-1:0]  refill_vpn_o,
    output logic [tlb_pkg::ASID_W-1:0] refill_asid_o,
    output logic [tlb_pkg::PPN_W-1:0]  refill_ppn_o,
    output logic                       refill_global_o,
    output logic                       shared_hit_o
);
    import tlb_pkg::*;

    logic [SET_W-1:0]                  lookup_set;
    req_src_e                          lookup_src;
    logic [VPN_W-1:0]                  lookup_vpn;
    logic [ASID_W-1:0]                 lookup_asid;

    logic [TLB_WAYS-1:0]               wr_way;
    logic [TLB_WAYS-1:0]               way_wr_en;
    logic [TLB_SETS-1:0]               way0_valid_vec;
    logic [TLB_SETS-1:0]               way1_valid_vec;

    logic [TLB_WAYS-1:0]               way_valid;
    logic [TLB_WAYS-1:0][TAG_W-1:0]    way_tag;
    logic [TLB_WAYS-1:0][ASID_W-1:0]   way_asid;
    logic [TLB_WAYS-1:0][PPN_W-1:0]    way_ppn;
    logic [TLB_WAYS-1:0]               way_global;

    tlb_miss_arbiter i_arbiter (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vpn_i             (itlb_vpn_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vpn_i             (dtlb_vpn_i),
        .asid_i                 (asid_i),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o),
        .lookup_set_o           (lookup_set),
        .lookup_src_o           (lookup_src),
        .lookup_vpn_o           (lookup_vpn),
        .lookup_asid_o          (lookup_asid)
    );

    ////////////////////
    // ways
    ////////////////////

    assign way_wr_en = flush_i ? '0 : wr_way;   // flush drops a same-cycle update

    tlb_way_store i_way0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rd_set_i     (lookup_set),
        .wr_en_i      (way_wr_en[0]),
        .wr_vpn_i     (upd_vpn_i),
        .wr_asid_i    (upd_asid_i),
        .wr_ppn_i     (upd_ppn_i),
        .wr_global_i  (upd_global_i),
        .flush_i      (flush_i),
        .flush_vpn_i  (flush_vpn_i),
        .flush_asid_i (flush_asid_i),
        .valid_vec_o  (way0_valid_vec),
        .rd_valid_o   (way_valid[0]),
        .rd_tag_o     (way_tag[0]),
        .rd_asid_o    (way_asid[0]),
        .rd_ppn_o     (way_ppn[0]),
        .rd_global_o  (way_global[0])
    );

    tlb_way_store i_way1 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rd_set_i     (lookup_set),
        .wr_en_i      (way_wr_en[1]),
        .wr_vpn_i     (upd_vpn_i),
        .wr_asid_i    (upd_asid_i),
        .wr_ppn_i     (upd_ppn_i),
        .wr_global_i  (upd_global_i),
        .flush_i      (flush_i),
        .flush_vpn_i  (flush_vpn_i),
        .flush_asid_i (flush_asid_i),
        .valid_vec_o  (way1_valid_vec),
        .rd_valid_o   (way_valid[1]),
        .rd_tag_o     (way_tag[1]),
        .rd_asid_o    (way_asid[1]),
        .rd_ppn_o     (way_ppn[1]),
        .rd_global_o  (way_global[1])
    );

    tlb_replacement i_repl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .upd_valid_i  (upd_valid_i),
        .upd_set_i    (upd_vpn_i[SET_W-1:0]),
        .way0_valid_i (way0_valid_vec),
        .way1_valid_i (way1_valid_vec),
        .wr_way_o     (wr_way)
    );

    tlb_hit_select i_hit (
        .lookup_src_i        (lookup_src),
        .lookup_vpn_i        (lookup_vpn),
        .lookup_asid_i       (lookup_asid),
        .way_valid_i         (way_valid),
        .way_tag_i           (way_tag),
        .way_asid_i          (way_asid),
        .way_ppn_i           (way_ppn),
        .way_global_i        (way_global),
        .shared_hit_o        (shared_hit_o),
        .itlb_refill_valid_o (itlb_refill_valid_o),
        .dtlb_refill_valid_o (dtlb_refill_valid_o),
        .refill_vpn_o        (refill_vpn_o),
        .refill_asid_o       (refill_asid_o),
        .refill_ppn_o        (refill_ppn_o),
        .refill_global_o     (refill_global_o)
    );

endmodule

/* sim/tlb_checker.sv */
module tlb_checker (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       enable_translation_i,
    input  logic                       en_ld_st_translation_i,
    input  logic [tlb_pkg::ASID_W-1:0] asid_i,
    input  logic                       itlb_access_i,
    input  logic                       itlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  itlb_vpn_i,
    input  logic                       dtlb_access_i,
    input  logic                       dtlb_hit_i,
    input  logic [tlb_pkg::VPN_W-1:0]  dtlb_vpn_i,
    input  logic                       upd_valid_i,
    input  logic [tlb_pkg::VPN_W-1:0]  upd_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0] upd_asid_i,
    input  logic [tlb_pkg::PPN_W-1:0]  upd_ppn_i,
    input  logic                       upd_global_i,
    input  logic                       flush_i,
    input  logic [tlb_pkg::ASID_W-1:0] flush_asid_i,
    input  logic [tlb_pkg::VPN_W-1:0]  flush_vpn_i,
    input  logic                       itlb_miss_i,
    input  logic                       dtlb_miss_i,
    input  logic                       itlb_refill_valid_i,
    input  logic                       dtlb_refill_valid_i,
    input  logic [tlb_pkg::VPN_W-1:0]  refill_vpn_i,
    input  logic [tlb_pkg::ASID_W-1:0] refill_asid_i,
    input  logic [tlb_pkg::PPN_W-1:0]  refill_ppn_i,
    input  logic                       refill_global_i,
    input  logic                       shared_hit_i
);
    import tlb_pkg::*;

    localparam int SLOTS = 64;

    // model table, flat, set taken from the vpn
    logic              m_valid  [SLOTS];
    logic [VPN_W-1:0]  m_vpn    [SLOTS];
    logic [ASID_W-1:0] m_asid   [SLOTS];
    logic [PPN_W-1:0]  m_ppn    [SLOTS];
    logic              m_glob   [SLOTS];
    logic              m_unsure [SLOTS];  // may have been evicted

    int error_count = 0;
    int check_count = 0;
    int unsure_hits = 0;

    req_src_e          pend_src;
    logic [VPN_W-1:0]  pend_vpn;
    logic [ASID_W-1:0] pend_asid;
    logic              exp_hit;
    logic [PPN_W-1:0]  exp_ppn;
    logic              exp_glob;
    logic              exp_unsure;

    function automatic logic ref_lookup(input logic [VPN_W-1:0] vpn,
                                        input logic [ASID_W-1:0] asid,
                                        output logic [PPN_W-1:0] ppn,
                                        output logic glob, output logic unsure);
        ppn    = '0;
        glob   = 1'b0;
        unsure = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            if (m_valid[s] && m_vpn[s] == vpn && (m_asid[s] == asid || m_glob[s])) begin
                ppn    = m_ppn[s];
                glob   = m_glob[s];
                unsure = m_unsure[s];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_value(input string msg);
        error_count++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    ////////////////////
    // model updates
    ////////////////////

    task automatic apply_flush();
        logic vz;
        logic az;
        vz = (flush_vpn_i == '0);
        az = (flush_asid_i == '0);
        for (int s = 0; s < SLOTS; s++) begin
            if (vz && az) begin
                m_valid[s] = 1'b0;
            end else if (az) begin
                if (m_vpn[s] == flush_vpn_i) m_valid[s] = 1'b0;
            end else if (!vz) begin
                if (m_vpn[s] == flush_vpn_i && m_asid[s] == flush_asid_i && !m_glob[s])
                    m_valid[s] = 1'b0;
            end else if (m_asid[s] == flush_asid_i && !m_glob[s]) begin
                m_valid[s] = 1'b0;                  // globals survive
            end
        end
    endtask

    task automatic add_entry();
        int cnt;
        int free;
        cnt  = 0;
        free = -1;
        for (int s = 0; s < SLOTS; s++) begin
            if (m_valid[s] && m_vpn[s][SET_W-1:0] == upd_vpn_i[SET_W-1:0]) cnt++;
            if (!m_valid[s] && free < 0) free = s;
        end
        if (cnt >= 2) begin
            // victim picked at random, either older entry may go
            for (int s = 0; s < SLOTS; s++) begin
                if (m_valid[s] && m_vpn[s][SET_W-1:0] == upd_vpn_i[SET_W-1:0])
                    m_unsure[s] = 1'b1;
            end
        end
        m_valid[free]  = 1'b1;
        m_vpn[free]    = upd_vpn_i;
        m_asid[free]   = upd_asid_i;
        m_ppn[free]    = upd_ppn_i;
        m_glob[free]   = upd_global_i;
        m_unsure[free] = 1'b0;
    endtask

    ////////////////////
    // compare
    ////////////////////

    task automatic compare_refill();
        if (pend_src == SRC_NONE) begin
            if (shared_hit_i || itlb_refill_valid_i || dtlb_refill_valid_i)
                report_value("refill raised without a served miss");
            return;
        end
        check_count++;
        if (shared_hit_i) begin
            if (!exp_hit) begin
                report_value($sformatf("unexpected hit vpn %h asid %h", pend_vpn, pend_asid));
            end else begin
                if (exp_unsure) unsure_hits++;
                if (itlb_refill_valid_i !== (pend_src == SRC_ITLB)
                    || dtlb_refill_valid_i !== (pend_src == SRC_DTLB))
                    report_value($sformatf("refill on wrong side for vpn %h", pend_vpn));
                if (refill_ppn_i !== exp_ppn || refill_global_i !== exp_glob)
                    report_value($sformatf("vpn %h ppn %h g %b, expected ppn %h g %b",
                        pend_vpn, refill_ppn_i, refill_global_i, exp_ppn, exp_glob));
                if (refill_vpn_i !== pend_vpn || refill_asid_i !== pend_asid)
                    report_value($sformatf("refill tag %h/%h, expected %h/%h",
                        refill_vpn_i, refill_asid_i, pend_vpn, pend_asid));
            end
        end else begin
            if (itlb_refill_valid_i || dtlb_refill_valid_i)
                report_value("refill valid without shared hit");
            if (exp_hit && !exp_unsure) begin
                error_count++;
                $display("missing refill at %0t: vpn %h asid %h was expected to hit",
                         $time, pend_vpn, pend_asid);
            end
        end
    endtask

    // sampled mid-cycle, inputs and registered outputs are settled
    always @(negedge clk_i) begin : watch
        logic serve_d;
        logic serve_i;
        if (!rst_ni) begin
            for (int s = 0; s < SLOTS; s++) m_valid[s] = 1'b0;
            pend_src = SRC_NONE;
        end else begin
            compare_refill();
            serve_d = !flush_i && en_ld_st_translation_i && dtlb_access_i && !dtlb_hit_i;
            serve_i = !flush_i && enable_translation_i && itlb_access_i && !itlb_hit_i
                      && !dtlb_access_i;
            if (dtlb_miss_i !== serve_d || itlb_miss_i !== serve_i)
                report_value($sformatf("miss outputs i=%b d=%b, expected i=%b d=%b",
                    itlb_miss_i, dtlb_miss_i, serve_i, serve_d));
            pend_src  = serve_d ? SRC_DTLB : (serve_i ? SRC_ITLB : SRC_NONE);
            pend_vpn  = serve_d ? dtlb_vpn_i : itlb_vpn_i;
            pend_asid = asid_i;
            exp_hit   = ref_lookup(pend_vpn, pend_asid, exp_ppn, exp_glob, exp_unsure);
            if (flush_i) apply_flush();
            else if (upd_valid_i) add_entry();  // flush wins over update
        end
    end

endmodule

/* sim/tb_shared_tlb.sv */
module tb_shared_tlb;
    import tlb_pkg::*;

    localparam int FILL_CYC  = 160;
    localparam int PRIO_CYC  = 20;
    localparam int ASID_CYC  = 50;
    localparam int FLUSH_CYC = 200;
    localparam int REPL_CYC  = 20;
    localparam int TIMEOUT   = (FILL_CYC + PRIO_CYC + ASID_CYC + FLUSH_CYC + REPL_CYC) * 2;
    localparam int N_ENT     = 20;

    logic              clk_i;
    logic              rst_ni;
    logic              enable_translation_i;
    logic              en_ld_st_translation_i;
    logic [ASID_W-1:0] asid_i;
    logic              itlb_access_i;
    logic              itlb_hit_i;
    logic [VPN_W-1:0]  itlb_vpn_i;
    logic              dtlb_access_i;
    logic              dtlb_hit_i;
    logic [VPN_W-1:0]  dtlb_vpn_i;
    logic              upd_valid_i;
    logic [VPN_W-1:0]  upd_vpn_i;
    logic [ASID_W-1:0] upd_asid_i;
    logic [PPN_W-1:0]  upd_ppn_i;
    logic              upd_global_i;
    logic              flush_i;
    logic [ASID_W-1:0] flush_asid_i;
    logic [VPN_W-1:0]  flush_vpn_i;
    logic              itlb_miss_o;
    logic              dtlb_miss_o;
    logic              itlb_refill_valid_o;
    logic              dtlb_refill_valid_o;
    logic [VPN_W-1:0]  refill_vpn_o;
    logic [ASID_W-1:0] refill_asid_o;
    logic [PPN_W-1:0]  refill_ppn_o;
    logic              refill_global_o;
    logic              shared_hit_o;

    logic [31:0]       rng = 32'd94245;
    logic [VPN_W-1:0]  tv_vpn  [N_ENT];
    logic [ASID_W-1:0] tv_asid [N_ENT];
    int                tb_errors = 0;
    int                mark = 0;
    int                passed = 0;
    int                failed = 0;
    int                cycles = 0;

    shared_tlb i_dut (.*);

    tlb_checker i_chk (
        .itlb_miss_i         (itlb_miss_o),
        .dtlb_miss_i         (dtlb_miss_o),
        .itlb_refill_valid_i (itlb_refill_valid_o),
        .dtlb_refill_valid_i (dtlb_refill_valid_o),
        .refill_vpn_i        (refill_vpn_o),
        .refill_asid_i       (refill_asid_o),
        .refill_ppn_i        (refill_ppn_o),
        .refill_global_i     (refill_global_o),
        .shared_hit_i        (shared_hit_o),
        .*
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift(rng);
        return rng;
    endfunction

    ////////////////////
    // bus drivers
    ////////////////////

    task automatic write_entry(input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid,
                               input logic glob);
        @(posedge clk_i);
        upd_valid_i  <= 1'b1;
        upd_vpn_i    <= vpn;
        upd_asid_i   <= asid;
        upd_ppn_i    <= PPN_W'(draw());
        upd_global_i <= glob;
        @(posedge clk_i);
        upd_valid_i  <= 1'b0;
    endtask

    // side 1 is the itlb and 0 the dtlb
    task automatic lookup(input logic side, input logic [VPN_W-1:0] vpn,
                          input logic [ASID_W-1:0] asid);
        @(posedge clk_i);
        asid_i        <= asid;
        itlb_access_i <= side;
        itlb_vpn_i    <= vpn;
        dtlb_access_i <= !side;
        dtlb_vpn_i    <= vpn;
        @(posedge clk_i);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;
    endtask

    task automatic flush_cmd(input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid,
                             input logic with_upd);
        @(posedge clk_i);
        flush_i      <= 1'b1;
        flush_vpn_i  <= vpn;
        flush_asid_i <= asid;
        upd_valid_i  <= with_upd;
        upd_vpn_i    <= 27'h155_5555;
        upd_asid_i   <= asid_i;
        @(posedge clk_i);
        flush_i      <= 1'b0;
        upd_valid_i  <= 1'b0;
    endtask

    task automatic lookup_all();
        for (int i = 0; i < N_ENT; i++) lookup(1'b0, tv_vpn[i], tv_asid[i]);
    endtask

    task automatic end_test(input string name);
        int errs;
        repeat (3) @(posedge clk_i);
        errs = i_chk.error_count + tb_errors - mark;
        mark = i_chk.error_count + tb_errors;
        if (errs == 0) passed++;
        else failed++;
        $display("test %-12s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic fill_and_hit();
        int set_cnt [TLB_SETS];
        logic [VPN_W-1:0] vpn;
        for (int s = 0; s < TLB_SETS; s++) set_cnt[s] = 0;
        for (int i = 0; i < N_ENT; i++) begin
            do begin
                vpn = VPN_W'(draw());
            end while (vpn == '0 || set_cnt[vpn[SET_W-1:0]] >= 2);
            set_cnt[vpn[SET_W-1:0]]++;
            tv_vpn[i]  = vpn;
            tv_asid[i] = ASID_W'(draw() % 15 + 1);
            write_entry(vpn, tv_asid[i], draw() % 4 == 0);
        end
        for (int i = 0; i < N_ENT; i++) begin
            lookup(1'b0, tv_vpn[i], tv_asid[i]);
            lookup(1'b1, tv_vpn[i], tv_asid[i]);
        end
        for (int i = 0; i < 5; i++) lookup(i[0], VPN_W'(draw()), 4'h1);  // unknown pages
        end_test("fill_hit");
    endtask

    task automatic priority_check();
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge clk_i);
            enable_translation_i   <= (pass == 0);
            en_ld_st_translation_i <= (pass == 0);
            asid_i        <= tv_asid[1];
            itlb_access_i <= 1'b1;
            itlb_vpn_i    <= tv_vpn[0];
            dtlb_access_i <= 1'b1;
            dtlb_vpn_i    <= tv_vpn[1];
            @(posedge clk_i);
            itlb_access_i <= 1'b0;
            dtlb_access_i <= 1'b0;
        end
        @(posedge clk_i);
        enable_translation_i   <= 1'b1;
        en_ld_st_translation_i <= 1'b1;
        end_test("priority");
    endtask

    task automatic asid_global();
        for (int i = 0; i < N_ENT; i++) lookup(i[0], tv_vpn[i], tv_asid[i] ^ 4'h3);
        end_test("asid_global");
    endtask

    task automatic flush_cases();
        flush_cmd(tv_vpn[0], tv_asid[0], 1'b0);     // address and asid
        lookup_all();
        flush_cmd(tv_vpn[1], '0, 1'b0);             // address in every space
        lookup_all();
        flush_cmd('0, tv_asid[2], 1'b0);            // asid only with globals kept
        lookup_all();
        flush_cmd('0, '0, 1'b1);                    // all entries and the same-cycle update
        lookup_all();
        lookup(1'b0, 27'h155_5555, asid_i);
        end_test("flush");
    endtask

    task automatic replacement();
        logic [VPN_W-1:0] rv [3];
        int start;
        int survived;
        for (int i = 0; i < 3; i++) begin
            rv[i] = {(VPN_W-SET_W)'(draw() % 1000 + 1), 4'h5};
            write_entry(rv[i], 4'h2, 1'b0);
        end
        start = i_chk.unsure_hits;
        for (int i = 0; i < 3; i++) lookup(1'b0, rv[i], 4'h2);
        repeat (2) @(posedge clk_i);
        survived = i_chk.unsure_hits - start;
        if (survived != 1) begin
            tb_errors++;
            $display("[ERROR] %0t expected one older entry to survive, %0d did",
                     $time, survived);
        end
        end_test("replacement");
    endtask

    initial begin
        rst_ni = 1'b0;
        enable_translation_i = 1'b1;
        en_ld_st_translation_i = 1'b1;
        asid_i = '0;
        itlb_access_i = 1'b0;
        itlb_hit_i = 1'b0;
        itlb_vpn_i = '0;
        dtlb_access_i = 1'b0;
        dtlb_hit_i = 1'b0;
        dtlb_vpn_i = '0;
        upd_valid_i = 1'b0;
        upd_vpn_i = '0;
        upd_asid_i = '0;
        upd_ppn_i = '0;
        upd_global_i = 1'b0;
        flush_i = 1'b0;
        flush_asid_i = '0;
        flush_vpn_i = '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        fill_and_hit();
        priority_check();
        asid_global();
        flush_cases();
        replacement();
        $display("tests %0d passed, %0d failed, %0d refills checked, %0d errors",
                 passed, failed, i_chk.check_count, i_chk.error_count + tb_errors);
        if (failed == 0 && i_chk.error_count + tb_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // hang guard
    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* build.f */
verilog/tlb_pkg.sv
verilog/tlb_miss_arbiter.sv
verilog/tlb_way_store.sv
verilog/tlb_replacement.sv
verilog/tlb_hit_select.sv
verilog/shared_tlb.sv
sim/tlb_checker.sv
sim/tb_shared_tlb.sv
